/* files.f */
+incdir+include
src/mem_pkg.sv
src/bank_arbiter.sv
src/sram_bank.sv
src/ack_return.sv
src/mem_ctrl_top.sv
tests/mem_ctrl_chk.sv
tests/mem_ctrl_tb.sv

/* include/mem_settings.svh */
// Sizing macros for the banked memory controller
// Port count, bank geometry, data and address widths
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Requesting ports, port 0 has highest priority
`define MEM_PORTS 4

// Independent banks, each with its own arbiter
`define MEM_BANKS 4

// Words per bank
`define MEM_BANK_WORDS 1024

`define MEM_DATA_W 32 // Bits per word

// Word address, top bits select the bank
`define MEM_ADDR_W 12

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module mem_ctrl_tb -f files.f -o mem_ctrl_sim

# Result is taken from the log, not from the exit status
./obj_dir/mem_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* src/ack_return.sv */
// Return path from the banks to the ports
// Builds each port's ack and selects its read data from the owning bank
`timescale 1ns/1ns
`include "mem_settings.svh"

module ack_return (
    input  mem_pkg::bank_status_t status     [`MEM_BANKS],
    input  mem_pkg::data_t        bank_rdata [`MEM_BANKS],
    output logic [`MEM_PORTS-1:0] ack,
    output mem_pkg::data_t        rd_data    [`MEM_PORTS]
);
    import mem_pkg::*;

    // At most one busy bank owns a given port
    // so the OR of matches never mixes two banks
    always_comb begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            ack[p]     = 1'b0;
            rd_data[p] = '0; // Zero when no bank serves the port
            for (int b = 0; b < `MEM_BANKS; b++) begin
                if (status[b].busy && (status[b].owner == port_id_t'(p))) begin
                    ack[p]     = 1'b1;
                    rd_data[p] = bank_rdata[b];
                end
            end
        end
    end

endmodule

/* src/bank_arbiter.sv */
// Fixed-priority arbiter for one memory bank
// Owns the bank for the whole req/ack transaction of the winning port
`timescale 1ns/1ns
`include "mem_settings.svh"

module bank_arbiter #(
    parameter mem_pkg::bank_sel_t BANK_ID = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MEM_PORTS-1:0] req,
    input  mem_pkg::port_req_t    port_req [`MEM_PORTS],
    output logic                  mem_en,
    output logic                  mem_we,
    output mem_pkg::offset_t      mem_offset,
    output mem_pkg::data_t        mem_wdata,
    output mem_pkg::bank_status_t status
);
    import mem_pkg::*;

    logic [`MEM_PORTS-1:0] hit; // Requesting ports that address this bank
    logic                  grant;
    port_id_t              pick;
    port_req_t             sel_req;
    bank_status_t          state_q;

    // Bank select compare for every port
    always_comb begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            hit[p] = req[p] &&
                (port_req[p].addr[$bits(addr_t)-1 -: $bits(bank_sel_t)] == BANK_ID);
        end
    end

    // Lowest-numbered hit wins
    always_comb begin
        pick = '0;
        for (int p = `MEM_PORTS - 1; p >= 0; p--) begin
            if (hit[p]) begin
                pick = port_id_t'(p);
            end
        end
    end

    // Only an idle bank takes a new owner
    // While busy, the owner is the one port being served
    assign grant = !state_q.busy && (|hit);

    assign sel_req = port_req[pick];

    // Single-cycle access at the grant edge
    assign mem_en     = grant;
    assign mem_we     = sel_req.write;
    assign mem_offset = sel_req.addr[$bits(offset_t)-1:0];
    assign mem_wdata  = sel_req.wdata;

    // Ownership tracking
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q.busy  <= 1'b0;
            state_q.owner <= '0;
        end else if (grant) begin
            state_q.busy  <= 1'b1;
            state_q.owner <= pick;
        end else if (state_q.busy && !req[state_q.owner]) begin
            state_q.busy <= 1'b0; // Owner dropped req, ack falls next cycle
        end
    end

    // Others on this bank wait as long as the owner keeps req high

    assign status = state_q;

endmodule

/* src/mem_ctrl_top.sv */
// Four-port, four-bank memory controller top level
// One arbiter and one bank per address range plus the shared return path
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_ctrl_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MEM_PORTS-1:0] req,
    input  mem_pkg::port_req_t    port_req [`MEM_PORTS],
    output logic [`MEM_PORTS-1:0] ack,
    output mem_pkg::data_t        rd_data  [`MEM_PORTS]
);
    import mem_pkg::*;

    // Arbiter to bank
    logic [`MEM_BANKS-1:0] mem_en;
    logic [`MEM_BANKS-1:0] mem_we;
    offset_t               mem_offset [`MEM_BANKS];
    data_t                 mem_wdata  [`MEM_BANKS];

    // Bank side to return path
    data_t                 bank_rdata  [`MEM_BANKS];
    bank_status_t          bank_status [`MEM_BANKS];

    // One arbiter and bank pair per address range
    for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
        bank_arbiter #(
            .BANK_ID(bank_sel_t'(b))
        ) i_bank_arbiter (
            .clk        (clk),
            .reset      (reset),
            .req        (req),
            .port_req   (port_req),
            .mem_en     (mem_en[b]),
            .mem_we     (mem_we[b]),
            .mem_offset (mem_offset[b]),
            .mem_wdata  (mem_wdata[b]),
            .status     (bank_status[b])
        );

        sram_bank i_sram_bank (
            .clk    (clk),
            .en     (mem_en[b]),
            .we     (mem_we[b]),
            .offset (mem_offset[b]),
            .wdata  (mem_wdata[b]),
            .rdata  (bank_rdata[b])
        );
    end

    ack_return i_ack_return (
        .status     (bank_status),
        .bank_rdata (bank_rdata),
        .ack        (ack),
        .rd_data    (rd_data)
    );

endmodule

/* src/mem_pkg.sv */
// Shared types for the banked memory controller
// Address fields, port request and bank status structs
`include "mem_settings.svh"

package mem_pkg;

    // Full word address as seen by a port
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    typedef logic [`MEM_DATA_W-1:0] data_t; // One memory word

    // Upper address bits, pick one bank
    typedef logic [$clog2(`MEM_BANKS)-1:0] bank_sel_t;

    // Lower address bits, word within a bank
    typedef logic [$clog2(`MEM_BANK_WORDS)-1:0] offset_t;

    typedef logic [$clog2(`MEM_PORTS)-1:0] port_id_t; // Requesting port number

    // One access from a port, held stable while req is high
    typedef struct packed {
        logic  write; // 1 for write, 0 for read
        addr_t addr;
        data_t wdata; // Ignored on reads
    } port_req_t;

    // Bank state published by its arbiter
    // The return path uses it to route ack and read data
    typedef struct packed {
        logic     busy;  // Bank owned by a port
        port_id_t owner; // Valid only while busy
    } bank_status_t;

endpackage

/* src/sram_bank.sv */
// Single-port storage bank, one word per cycle
// Synchronous write, registered read data
`timescale 1ns/1ns
`include "mem_settings.svh"

module sram_bank (
    input  logic             clk,
    input  logic             en,
    input  logic             we,
    input  mem_pkg::offset_t offset,
    input  mem_pkg::data_t   wdata,
    output mem_pkg::data_t   rdata
);
    import mem_pkg::*;

    localparam int unsigned DEPTH = `MEM_BANK_WORDS;

    data_t mem [DEPTH]; // Contents survive reset

    // Writes leave rdata unchanged
    // A read updates rdata at the grant edge and it holds until the next read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[offset] <= wdata;
            end else begin
                rdata <= mem[offset]; // Valid while the owner sees ack
            end
        end
    end

endmodule

/* tests/mem_ctrl_chk.sv */
// Bound checks for the memory controller top level
// Four-phase req/ack rules and one owner per port across the banks
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_ctrl_chk (
    input logic                  clk,
    input logic                  reset,
    input logic [`MEM_PORTS-1:0] req,
    input logic [`MEM_PORTS-1:0] ack,
    input mem_pkg::bank_status_t bank_status [`MEM_BANKS]
);
    import mem_pkg::*;

    int   fail_count = 0; // Failed assertions so far
    logic owner_clash;    // Two busy banks claim one port

    always_comb begin
        owner_clash = 1'b0;
        for (int a = 0; a < `MEM_BANKS; a++) begin
            for (int b = a + 1; b < `MEM_BANKS; b++) begin
                if (bank_status[a].busy && bank_status[b].busy &&
                    (bank_status[a].owner == bank_status[b].owner)) begin
                    owner_clash = 1'b1;
                end
            end
        end
    end

    for (genvar p = 0; p < `MEM_PORTS; p++) begin : g_port
        // A new ack only answers a pending req
        assert property (@(posedge clk) disable iff (reset) $rose(ack[p]) |-> req[p])
        else begin
            $error("Port %0d ack rose without req", p);
            fail_count++;
        end

        assert property (@(posedge clk) disable iff (reset) ack[p] && req[p] |=> ack[p])
        else begin
            $error("Port %0d ack fell while req was still high", p);
            fail_count++;
        end

        // Ack follows a dropped req one cycle later
        assert property (@(posedge clk) disable iff (reset) ack[p] && !req[p] |=> !ack[p])
        else begin
            $error("Port %0d ack stayed high after req fell", p);
            fail_count++;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !owner_clash)
    else begin
        $error("Two busy banks have the same owner");
        fail_count++;
    end

    assert property (@(posedge clk) reset |=> (ack == '0)) // Clean start
    else begin
        $error("An ack was high right after reset");
        fail_count++;
    end

endmodule

bind mem_ctrl_top mem_ctrl_chk i_mem_ctrl_chk (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .ack         (ack),
    .bank_status (bank_status)
);

/* tests/mem_ctrl_tb.sv */
// Testbench for the four-port banked memory controller
// Directed and LFSR-random req/ack traffic checked against a memory model
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_ctrl_tb;
    import mem_pkg::*;

    localparam int DIRECTED_TXNS  = 16;
    localparam int RAND_ROUNDS    = 50; // One access per port in each round
    localparam int TXN_COUNT      = DIRECTED_TXNS + RAND_ROUNDS * `MEM_PORTS;
    localparam int TIMEOUT_CYCLES = 20 * TXN_COUNT;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [`MEM_PORTS-1:0] req;
    port_req_t             port_req [`MEM_PORTS];
    logic [`MEM_PORTS-1:0] ack;
    data_t                 rd_data  [`MEM_PORTS];

    data_t                 model_mem [1 << `MEM_ADDR_W]; // Expected contents
    addr_t                 written_q [$];                // Addresses safe to read
    port_req_t             rand_txn  [`MEM_PORTS];
    logic [15:0]           lfsr_state;
    logic [`MEM_PORTS-1:0] ack_prev;
    int                    cycles;
    int                    rise_cyc  [`MEM_PORTS]; // Cycle of the last ack rise
    int                    fall_cyc  [`MEM_PORTS];

    mem_ctrl_top i_mem_ctrl_top (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .port_req (port_req),
        .ack      (ack),
        .rd_data  (rd_data)
    );

    always #5 clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]}; // One step per bit
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input int bank, input int offset);
        return {bank_sel_t'(bank), offset_t'(offset)};
    endfunction

    function automatic port_req_t make_req(input logic wr, input addr_t a, input data_t d);
        port_req_t r;
        r.write = wr;
        r.addr  = a;
        r.wdata = d;
        return r;
    endfunction

    // Reads only go to addresses written in earlier rounds
    function automatic port_req_t random_txn();
        port_req_t   t;
        logic [31:0] rnd;
        int          idx;
        rnd     = rand_bits(1);
        t.write = rnd[0] || (written_q.size() == 0);
        if (t.write) begin
            rnd     = rand_bits(`MEM_ADDR_W);
            t.addr  = rnd[`MEM_ADDR_W-1:0];
            t.wdata = rand_bits(`MEM_DATA_W);
        end else begin
            rnd     = rand_bits(16);
            idx     = int'(rnd[15:0]) % written_q.size();
            t.addr  = written_q[idx];
            t.wdata = '0;
        end
        return t;
    endfunction

    // Reference memory, applied in ack order
    // A write updates the word, a read returns the expected value
    function automatic data_t model_access(input port_req_t r);
        if (r.write) begin
            model_mem[r.addr] = r.wdata;
        end
        return model_mem[r.addr];
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic raise_req(input port_id_t p, input port_req_t r);
        port_req[p] <= r;
        req[p]      <= 1'b1;
    endtask

    // Sampled at the clock edge, before the DUT updates
    task automatic wait_ack(input port_id_t p, input logic level);
        @(posedge clk);
        while (ack[p] !== level) begin
            @(posedge clk);
        end
    endtask

    // Full four-phase transaction on one port
    task automatic port_access(input port_id_t p, input port_req_t r);
        @(posedge clk);
        raise_req(p, r);
        wait_ack(p, 1'b1);
        req[p] <= 1'b0;
        wait_ack(p, 1'b0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: run still busy after %0d cycles", cycles));
        end
    end

    // Bound checker failures stop the run at the next edge
    always @(posedge clk) begin
        assert (i_mem_ctrl_top.i_mem_ctrl_chk.fail_count == 0) else
            report_failure("A bound handshake assertion failed");
    end

    // Compare on every ack rise, writes go into the model
    always @(posedge clk) begin
        data_t expected;
        for (int p = 0; p < `MEM_PORTS; p++) begin
            if (ack[p] && !ack_prev[p]) begin
                rise_cyc[p] <= cycles;
                expected = model_access(port_req[p]);
                if (!port_req[p].write) begin
                    assert (rd_data[p] === expected) else
                        report_failure($sformatf(
                            "MISMATCH rd_data[%0d] addr %h got %h expected %h",
                            p, port_req[p].addr, rd_data[p], expected));
                end
            end
            if (!ack[p] && ack_prev[p]) begin
                fall_cyc[p] <= cycles;
            end
        end
        ack_prev <= ack;
    end

    initial begin
        lfsr_state = 16'd57;
        reset <= 1'b1;
        req   <= '0;
        for (int p = 0; p < `MEM_PORTS; p++) begin
            port_req[p] <= '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (ack == '0) else
            report_failure($sformatf("MISMATCH ack got %h expected %h", ack, 4'h0));

        // Write then read back on a single port
        port_access(2'd0, make_req(1'b1, 12'h123, 32'hDEAD_BEEF));
        written_q.push_back(12'h123);
        port_access(2'd0, make_req(1'b0, 12'h123, '0));

        // Four banks written in the same cycle
        @(posedge clk);
        for (int b = 0; b < `MEM_PORTS; b++) begin
            raise_req(port_id_t'(b), make_req(1'b1, make_addr(b, 'h055), 32'hA000_0000 + 32'(b)));
            written_q.push_back(make_addr(b, 'h055));
        end
        @(posedge clk);
        while (ack == '0) begin
            @(posedge clk);
        end
        assert (ack == '1) else
            report_failure($sformatf("MISMATCH ack got %h expected %h", ack, 4'hf));
        req <= '0;
        for (int b = 0; b < `MEM_PORTS; b++) begin
            wait_ack(port_id_t'(b), 1'b0);
        end
        fork
            port_access(2'd0, make_req(1'b0, make_addr(1, 'h055), '0));
            port_access(2'd1, make_req(1'b0, make_addr(2, 'h055), '0));
            port_access(2'd2, make_req(1'b0, make_addr(3, 'h055), '0));
            port_access(2'd3, make_req(1'b0, make_addr(0, 'h055), '0));
        join

        // Three ports contend for bank 2
        fork
            port_access(2'd3, make_req(1'b1, make_addr(2, 'h010), 32'h3333_0003));
            port_access(2'd1, make_req(1'b1, make_addr(2, 'h020), 32'h1111_0001));
            port_access(2'd2, make_req(1'b1, make_addr(2, 'h030), 32'h2222_0002));
        join
        @(posedge clk);
        assert (rise_cyc[1] < rise_cyc[2] && rise_cyc[1] < rise_cyc[3]) else
            report_failure("Port 1 was not the first port acknowledged on bank 2");
        assert (rise_cyc[2] > fall_cyc[1]) else
            report_failure("Port 2 was acknowledged before the ack of port 1 fell");
        assert (rise_cyc[3] > fall_cyc[2]) else
            report_failure("Port 3 was acknowledged before the ack of port 2 fell");
        written_q.push_back(make_addr(2, 'h010));
        written_q.push_back(make_addr(2, 'h020));
        written_q.push_back(make_addr(2, 'h030));

        // Port 0 holds bank 1, port 2 waits, port 1 uses bank 2
        @(posedge clk);
        raise_req(2'd0, make_req(1'b1, make_addr(1, 'h100), 32'hC0DE_0100));
        wait_ack(2'd0, 1'b1);
        fork
            port_access(2'd1, make_req(1'b1, make_addr(2, 'h03c), 32'h0BAD_F00D));
            begin
                @(posedge clk);
                raise_req(2'd2, make_req(1'b0, make_addr(1, 'h100), '0));
            end
        join
        repeat (3) begin
            @(posedge clk);
            assert (!ack[2] && ack[0]) else
                report_failure("Port 2 got bank 1 while port 0 still held it");
        end
        req[0] <= 1'b0;
        wait_ack(2'd0, 1'b0);
        wait_ack(2'd2, 1'b1);
        req[2] <= 1'b0;
        wait_ack(2'd2, 1'b0);
        @(posedge clk);
        assert (rise_cyc[2] > fall_cyc[0]) else
            report_failure("Port 2 was acknowledged before port 0 released bank 1");
        written_q.push_back(make_addr(1, 'h100));
        written_q.push_back(make_addr(2, 'h03c));

        // Random rounds, all four ports at once
        for (int round = 0; round < RAND_ROUNDS; round++) begin
            rand_txn[0] = random_txn();
            rand_txn[1] = random_txn();
            rand_txn[2] = random_txn();
            rand_txn[3] = random_txn();
            fork
                port_access(2'd0, rand_txn[0]);
                port_access(2'd1, rand_txn[1]);
                port_access(2'd2, rand_txn[2]);
                port_access(2'd3, rand_txn[3]);
            join
            for (int p = 0; p < `MEM_PORTS; p++) begin
                if (rand_txn[p].write) begin
                    written_q.push_back(rand_txn[p].addr);
                end
            end
        end

        repeat (3) @(posedge clk);
        if (i_mem_ctrl_top.i_mem_ctrl_chk.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            report_failure($sformatf("Bound assertions failed %0d times",
                i_mem_ctrl_top.i_mem_ctrl_chk.fail_count));
        end
        $finish;
    end

endmodule
